//--- Makefile
SRCS := $(wildcard source/*.sv bench/*.sv)

.PHONY: run clean

run: obj_dir/Vdecode_tb
	@out=$$(./obj_dir/Vdecode_tb); echo "$$out"; \
	echo "$$out" | grep -qx "TESTS PASSED"

obj_dir/V%: $(SRCS) compile.f
	verilator --binary --assert -Wno-fatal -f compile.f --top-module $* -Mdir obj_dir

clean:
	rm -rf obj_dir

//--- bench/decode_chk.sv
module decode_chk (
	input logic             clk,
	input logic             rst_n,
	input logic             instr_valid,
	input logic [31:0]      instr,
	input logic             wb_valid,
	input rv_pkg::wb_t      wb,
	input logic             out_valid,
	input rv_pkg::decoded_t out
);
	timeunit 1ns;
	timeprecision 100ps;

	int          errors = 0;
	logic [31:0] shadow [32];
	logic [31:0] exp_rs1;
	logic [31:0] exp_rs2;

	function automatic rv_pkg::fmt_e fmt_of(input logic [6:0] op);
		case (op)
			rv_pkg::op_lui, rv_pkg::op_auipc: return rv_pkg::fmt_u;
			rv_pkg::op_jal: return rv_pkg::fmt_j;
			rv_pkg::op_jalr, rv_pkg::op_load, rv_pkg::op_itype,
			rv_pkg::op_fence, rv_pkg::op_system: return rv_pkg::fmt_i;
			rv_pkg::op_branch: return rv_pkg::fmt_b;
			rv_pkg::op_store: return rv_pkg::fmt_s;
			rv_pkg::op_rtype: return rv_pkg::fmt_r;
			default: return rv_pkg::fmt_none;
		endcase
	endfunction

	function automatic logic [31:0] imm_of(input logic [31:0] i);
		case (fmt_of(i[6:0]))
			rv_pkg::fmt_i: return {{20{i[31]}}, i[31:20]};
			rv_pkg::fmt_s: return {{20{i[31]}}, i[31:25], i[11:7]};
			rv_pkg::fmt_b: return {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
			rv_pkg::fmt_j: return {{11{i[31]}}, i[31], i[19:12], i[20], i[30:21], 1'b0};
			rv_pkg::fmt_u: return {i[31:12], 12'b0};
			default: return 32'b0;
		endcase
	endfunction

	// rd and funct3 together, zero where the format lacks them.
	function automatic logic [7:0] rd_f3_of(input logic [31:0] i);
		rv_pkg::fmt_e f;
		f = fmt_of(i[6:0]);
		return {(f == rv_pkg::fmt_b || f == rv_pkg::fmt_s || f == rv_pkg::fmt_none) ?
			5'd0 : i[11:7],
			(f == rv_pkg::fmt_u || f == rv_pkg::fmt_j || f == rv_pkg::fmt_none) ?
			3'd0 : i[14:12]};
	endfunction

	function automatic logic [3:0] alu_of(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000: return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001: return rv_pkg::alu_sll;
			3'b010: return rv_pkg::alu_slt;
			3'b011: return rv_pkg::alu_sltu;
			3'b100: return rv_pkg::alu_xor;
			3'b101: return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110: return rv_pkg::alu_or;
			default: return rv_pkg::alu_and;
		endcase
	endfunction

	// {alu_op, src_a_pc, src_b_imm, mem_read, mem_write, reg_write,
	// branch, jump, link, system, illegal}.
	function automatic logic [13:0] ctrl_of(input logic [31:0] i);
		logic [3:0] a;
		logic [9:0] f;
		a = rv_pkg::alu_add;
		f = 10'b0;
		case (i[6:0])
			rv_pkg::op_lui: begin
				a = rv_pkg::alu_pass_b;
				f = 10'b01_0010_0000;
			end
			rv_pkg::op_auipc: f = 10'b11_0010_0000;
			rv_pkg::op_jal: f = 10'b11_0010_1100;
			rv_pkg::op_jalr: f = 10'b01_0010_1100;
			rv_pkg::op_branch: begin
				f = 10'b00_0001_0000;
				a = (i[14:13] == 2'b00) ? rv_pkg::alu_sub :
					(i[14:13] == 2'b10) ? rv_pkg::alu_slt : rv_pkg::alu_sltu;
			end
			rv_pkg::op_load: f = 10'b01_1010_0000;
			rv_pkg::op_store: f = 10'b01_0100_0000;
			rv_pkg::op_itype: begin
				a = alu_of(i[14:12], i[14:12] == 3'b101 && i[30]);
				f = 10'b01_0010_0000;
			end
			rv_pkg::op_rtype: begin
				a = alu_of(i[14:12], i[30]);
				f = (i[31:25] == 7'h00 || i[31:25] == 7'h20) ? 10'b00_0010_0000 :
					10'b00_0000_0001;
			end
			rv_pkg::op_fence, rv_pkg::op_system: f = 10'b00_0000_0010;
			default: f = 10'b00_0000_0001; // illegal, no writes.
		endcase
		return {a, f};
	endfunction

	function automatic logic [31:0] read_reg(input logic [4:0] idx);
		if (idx == 5'd0) return 32'b0;
		if (wb_valid && wb.rd == idx) return wb.data; // bypass.
		return shadow[idx];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < 32; k++) shadow[k] <= '0;
			exp_rs1 <= '0;
			exp_rs2 <= '0;
		end else begin
			if (wb_valid && wb.rd != 5'd0) shadow[wb.rd] <= wb.data;
			if (instr_valid) begin
				exp_rs1 <= (fmt_of(instr[6:0]) inside {rv_pkg::fmt_i, rv_pkg::fmt_b,
					rv_pkg::fmt_s, rv_pkg::fmt_r}) ? read_reg(instr[19:15]) : 32'b0;
				exp_rs2 <= (fmt_of(instr[6:0]) inside {rv_pkg::fmt_b, rv_pkg::fmt_s,
					rv_pkg::fmt_r}) ? read_reg(instr[24:20]) : 32'b0;
			end
		end
	end

	a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid && out == '0)
		else begin
			$error("Mismatch at %0t: out_valid/out got %b/%h expected 0/0 in reset", $time,
				out_valid, out);
			errors++;
		end

	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == $past(instr_valid))
		else begin
			$error("Mismatch at %0t: out_valid got %b expected %b", $time, out_valid,
				$past(instr_valid));
			errors++;
		end

	a_imm: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out.imm == imm_of($past(instr)))
		else begin
			$error("Mismatch at %0t: out.imm got %h expected %h", $time, out.imm,
				imm_of($past(instr)));
			errors++;
		end

	a_rd_f3: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> {out.rd, out.funct3} == rd_f3_of($past(instr)))
		else begin
			$error("Mismatch at %0t: out.rd/funct3 got %h expected %h", $time,
				{out.rd, out.funct3}, rd_f3_of($past(instr)));
			errors++;
		end

	a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out.ctrl == ctrl_of($past(instr)))
		else begin
			$error("Mismatch at %0t: out.ctrl got %h expected %h", $time, out.ctrl,
				ctrl_of($past(instr)));
			errors++;
		end

	a_operands: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> out.rs1_data == exp_rs1 && out.rs2_data == exp_rs2)
		else begin
			$error("Mismatch at %0t: rs1_data/rs2_data got %h/%h expected %h/%h", $time,
				out.rs1_data, out.rs2_data, exp_rs1, exp_rs2);
			errors++;
		end

endmodule

bind decode_stage decode_chk chk_i (.*);

//--- bench/decode_tb.sv
module decode_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int reset_len = 10;
	localparam int cycle_limit = reset_len + 6 + 300 + 11 * 4 + 20 + 75 + 50;

	logic             clk;
	logic             rst_n;
	logic             instr_valid;
	logic [31:0]      instr;
	logic             wb_valid;
	rv_pkg::wb_t      wb;
	logic             out_valid;
	rv_pkg::decoded_t out;

	integer seed = 66610;
	int     cycles = 0;
	int     tests = 0;
	int     last_errors = 0;
	logic [6:0] opcodes [11] = '{rv_pkg::op_lui, rv_pkg::op_auipc, rv_pkg::op_jal,
		rv_pkg::op_jalr, rv_pkg::op_branch, rv_pkg::op_load, rv_pkg::op_store,
		rv_pkg::op_itype, rv_pkg::op_rtype, rv_pkg::op_fence, rv_pkg::op_system};

	decode_stage dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycle_limit) begin
			$display("run did not finish within %0d cycles", cycle_limit);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// one cycle of inputs, changed on the falling edge.
	task automatic drive(input logic iv, input logic [31:0] i, input logic wv,
		input logic [4:0] rd, input logic [31:0] data);
		@(negedge clk);
		instr_valid = iv;
		instr = i;
		wb_valid = wv;
		wb.rd = rd;
		wb.data = data;
	endtask

	task automatic finish_test(input string name);
		drive(1'b0, 32'b0, 1'b0, 5'd0, 32'b0);
		while (out_valid) @(negedge clk);
		tests++;
		$display("test %s done, %0d failures", name, dut_i.chk_i.errors - last_errors);
		last_errors = dut_i.chk_i.errors;
	endtask

	function automatic logic [31:0] random_instr(input logic [6:0] op);
		logic [31:0] r;
		r = $random(seed);
		return {r[31:7], op};
	endfunction

	initial begin
		rst_n = 1'b0;
		instr_valid = 1'b0;
		instr = '0;
		wb_valid = 1'b0;
		wb = '0;
		repeat (reset_len) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		repeat (5) drive(1'b0, 32'b0, 1'b0, 5'd0, 32'b0);
		finish_test("reset_idle");

		// random fields, every format, with random write-back.
		for (int n = 0; n < 300; n++) begin
			drive($random(seed) % 4 != 0, random_instr(opcodes[{$random(seed)} % 11]),
				$random(seed) % 2 == 0, 5'($random(seed)), $random(seed));
		end
		finish_test("random_formats");

		for (int k = 0; k < 11; k++) begin
			for (int n = 0; n < 4; n++) begin
				drive(1'b1, random_instr(opcodes[k]) | 32'h8000_0000, 1'b0, 5'd0, 32'b0);
			end
		end
		finish_test("negative_imm");

		drive(1'b1, 32'h4020_8133, 1'b0, 5'd0, 32'b0); // sub.
		drive(1'b1, 32'h0020_8133, 1'b0, 5'd0, 32'b0); // add.
		drive(1'b1, 32'h4020_d133, 1'b0, 5'd0, 32'b0); // sra.
		drive(1'b1, 32'h0220_8133, 1'b0, 5'd0, 32'b0); // bad funct7.
		drive(1'b1, 32'h8020_8133, 1'b0, 5'd0, 32'b0);
		drive(1'b1, 32'h4030_d093, 1'b0, 5'd0, 32'b0); // srai.
		drive(1'b1, 32'h0030_d093, 1'b0, 5'd0, 32'b0); // srli.
		drive(1'b1, 32'h4030_8093, 1'b0, 5'd0, 32'b0); // addi, no sub.
		for (int n = 0; n < 8; n++) begin
			drive(1'b1, {25'h1ab_cdef, 7'h7f - 7'(n * 9)}, 1'b0, 5'd0, 32'b0);
		end
		finish_test("control_word");

		for (int r = 0; r < 32; r++) begin
			drive(1'b0, 32'b0, 1'b1, 5'(r), 32'hc0de_0000 + r);
		end
		for (int r = 0; r < 32; r++) begin
			drive(1'b1, {7'h00, 5'(r + 1), 5'(r), 3'b000, 5'd3, rv_pkg::op_rtype},
				1'b0, 5'd0, 32'b0);
		end
		drive(1'b1, {7'h00, 5'd9, 5'd9, 3'b000, 5'd3, rv_pkg::op_rtype},
			1'b1, 5'd9, 32'h1234_5678); // same-cycle bypass.
		drive(1'b1, {7'h00, 5'd0, 5'd0, 3'b000, 5'd3, rv_pkg::op_rtype},
			1'b1, 5'd0, 32'hffff_ffff); // x0 stays zero.
		drive(1'b1, {7'h00, 5'd0, 5'd9, 3'b000, 5'd3, rv_pkg::op_rtype},
			1'b0, 5'd0, 32'b0);
		finish_test("register_file");

		$display("tests run %0d, assertion failures %0d", tests, dut_i.chk_i.errors);
		if (dut_i.chk_i.errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- compile.f
source/rv_pkg.sv
source/instr_fields.sv
source/imm_gen.sv
source/ctrl_decode.sv
source/reg_file.sv
source/decode_stage.sv
bench/decode_chk.sv
bench/decode_tb.sv

//--- source/ctrl_decode.sv
module ctrl_decode (
	input  rv_pkg::fields_t fields,
	output rv_pkg::ctrl_t   ctrl
);

	// alt selects sub or sra where funct3 allows it.
	function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
		rv_pkg::alu_op_e op;
		case (f3)
			3'b000:  op = alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
			3'b001:  op = rv_pkg::alu_sll;
			3'b010:  op = rv_pkg::alu_slt;
			3'b011:  op = rv_pkg::alu_sltu;
			3'b100:  op = rv_pkg::alu_xor;
			3'b101:  op = alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
			3'b110:  op = rv_pkg::alu_or;
			default: op = rv_pkg::alu_and;
		endcase
		return op;
	endfunction

	logic shift_alt;

	// i-type has no funct7 field, imm[10] is instr[30].
	assign shift_alt = (fields.funct3 == 3'b101) && fields.raw_imm[10];

	always_comb begin
		ctrl = '0;
		ctrl.alu_op = rv_pkg::alu_add;
		case (fields.opcode)
			rv_pkg::op_lui: begin
				ctrl.alu_op = rv_pkg::alu_pass_b;
				ctrl.src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_auipc: begin
				ctrl.src_a_pc = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_jal: begin
				ctrl.src_a_pc = 1'b1;
				ctrl.src_b_imm = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_jalr: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.jump = 1'b1;
				ctrl.link = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_branch: begin
				ctrl.branch = 1'b1;
				// compare op, target add lives in execute.
				case (fields.funct3[2:1])
					2'b00:   ctrl.alu_op = rv_pkg::alu_sub;
					2'b10:   ctrl.alu_op = rv_pkg::alu_slt;
					default: ctrl.alu_op = rv_pkg::alu_sltu;
				endcase
			end
			rv_pkg::op_load: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_store: begin
				ctrl.src_b_imm = 1'b1;
				ctrl.mem_write = 1'b1;
			end
			rv_pkg::op_itype: begin
				ctrl.alu_op = alu_from_funct3(fields.funct3, shift_alt);
				ctrl.src_b_imm = 1'b1;
				ctrl.reg_write = 1'b1;
			end
			rv_pkg::op_rtype: begin
				ctrl.alu_op = alu_from_funct3(fields.funct3, fields.funct7[5]);
				ctrl.reg_write = 1'b1;
				ctrl.illegal = (fields.funct7 != 7'h00) && (fields.funct7 != 7'h20);
			end
			rv_pkg::op_fence, rv_pkg::op_system: begin
				ctrl.system = 1'b1;
			end
			default: begin
				ctrl.illegal = 1'b1;
			end
		endcase
		if (ctrl.illegal) begin
			ctrl.reg_write = 1'b0;
			ctrl.mem_write = 1'b0;
		end
	end

endmodule

//--- source/decode_stage.sv
module decode_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             instr_valid,
	input  logic [31:0]      instr,
	input  logic             wb_valid,
	input  rv_pkg::wb_t      wb,
	output logic             out_valid,
	output rv_pkg::decoded_t out
);

	rv_pkg::fields_t  fields;
	rv_pkg::ctrl_t    ctrl;
	rv_pkg::decoded_t next;
	logic [31:0]      imm;
	logic [31:0]      rs1_data;
	logic [31:0]      rs2_data;

	instr_fields u_fields (
		.instr  (instr),
		.fields (fields)
	);

	imm_gen u_imm (
		.fields (fields),
		.imm    (imm)
	);

	ctrl_decode u_ctrl (
		.fields (fields),
		.ctrl   (ctrl)
	);

	// unused ports read x0, so absent operands come out zero.
	reg_file u_regs (
		.clk      (clk),
		.rst_n    (rst_n),
		.rs1      (fields.rs1),
		.rs2      (fields.rs2),
		.rs1_data (rs1_data),
		.rs2_data (rs2_data),
		.wb_valid (wb_valid),
		.wb       (wb)
	);

	always_comb begin
		next.rs1_data = rs1_data;
		next.rs2_data = rs2_data;
		next.imm = imm;
		next.rd = fields.rd;
		next.funct3 = fields.funct3;
		next.ctrl = ctrl;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out <= '0;
		end else begin
			out_valid <= instr_valid;
			if (instr_valid) out <= next; // hold between strobes.
		end
	end

endmodule

//--- source/imm_gen.sv
module imm_gen (
	input  rv_pkg::fields_t fields,
	output logic [31:0]     imm
);

	logic [19:0] raw;

	assign raw = fields.raw_imm;

	always_comb begin
		case (fields.fmt)
			rv_pkg::fmt_i, rv_pkg::fmt_s: begin
				imm = {{20{raw[11]}}, raw[11:0]};
			end

			rv_pkg::fmt_b: begin
				imm = {{19{raw[11]}}, raw[11:0], 1'b0}; // halfword aligned.
			end

			rv_pkg::fmt_j: begin
				imm = {{11{raw[19]}}, raw[19:0], 1'b0};
			end

			rv_pkg::fmt_u: begin
				imm = {raw, 12'b0}; // upper 20 bits.
			end

			default: begin
				imm = '0;
			end
		endcase
	end

endmodule

//--- source/instr_fields.sv
module instr_fields (
	input  logic [31:0]     instr,
	output rv_pkg::fields_t fields
);

	logic [6:0] opcode;

	assign opcode = instr[6:0];

	always_comb begin
		fields = '0;
		fields.opcode = opcode;
		case (opcode)
			rv_pkg::op_lui, rv_pkg::op_auipc: begin
				fields.fmt = rv_pkg::fmt_u;
				fields.rd = instr[11:7];
				fields.raw_imm = instr[31:12];
			end

			rv_pkg::op_jal: begin
				fields.fmt = rv_pkg::fmt_j;
				fields.rd = instr[11:7];
				// imm[20|10:1|11|19:12] scrambled in the encoding.
				fields.raw_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};
			end

			rv_pkg::op_jalr, rv_pkg::op_load, rv_pkg::op_itype,
			rv_pkg::op_fence, rv_pkg::op_system: begin
				fields.fmt = rv_pkg::fmt_i;
				fields.rd = instr[11:7];
				fields.funct3 = instr[14:12];
				fields.rs1 = instr[19:15];
				fields.raw_imm = {8'b0, instr[31:20]};
			end

			rv_pkg::op_branch: begin
				fields.fmt = rv_pkg::fmt_b;
				fields.funct3 = instr[14:12];
				fields.rs1 = instr[19:15];
				fields.rs2 = instr[24:20];
				fields.raw_imm = {8'b0, instr[31], instr[7], instr[30:25], instr[11:8]};
			end

			rv_pkg::op_store: begin
				fields.fmt = rv_pkg::fmt_s;
				fields.funct3 = instr[14:12];
				fields.rs1 = instr[19:15];
				fields.rs2 = instr[24:20];
				fields.raw_imm = {8'b0, instr[31:25], instr[11:7]};
			end

			rv_pkg::op_rtype: begin
				fields.fmt = rv_pkg::fmt_r;
				fields.rd = instr[11:7];
				fields.funct3 = instr[14:12];
				fields.rs1 = instr[19:15];
				fields.rs2 = instr[24:20];
				fields.funct7 = instr[31:25];
			end

			default: begin
				// unknown opcode, everything zero incl. opcode.
				fields = '0;
				fields.fmt = rv_pkg::fmt_none;
			end
		endcase
	end

endmodule

//--- source/reg_file.sv
module reg_file (
	input  logic          clk,
	input  logic          rst_n,
	input  logic [4:0]    rs1,
	input  logic [4:0]    rs2,
	output logic [31:0]   rs1_data,
	output logic [31:0]   rs2_data,
	input  logic          wb_valid,
	input  rv_pkg::wb_t   wb
);

	logic [31:0] regs [1:31]; // x0 is not stored.
	logic        wr_en;

	assign wr_en = wb_valid && (wb.rd != 5'd0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// same-cycle write wins over the stored value.
	always_comb begin
		if (rs1 == 5'd0) rs1_data = '0;
		else if (wr_en && wb.rd == rs1) rs1_data = wb.data;
		else rs1_data = regs[rs1];

		if (rs2 == 5'd0) rs2_data = '0;
		else if (wr_en && wb.rd == rs2) rs2_data = wb.data;
		else rs2_data = regs[rs2];
	end

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

	// major opcodes, rv32i base set.
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_itype  = 7'b0010011;
	localparam logic [6:0] op_rtype  = 7'b0110011;
	localparam logic [6:0] op_fence  = 7'b0001111;
	localparam logic [6:0] op_system = 7'b1110011;

	typedef enum logic [2:0] {
		fmt_none = 3'd0,
		fmt_u    = 3'd1,
		fmt_j    = 3'd2,
		fmt_i    = 3'd3,
		fmt_b    = 3'd4,
		fmt_s    = 3'd5,
		fmt_r    = 3'd6
	} fmt_e;

	// raw_imm holds the immediate bits packed low, unshifted.
	typedef struct packed {
		logic [6:0]  opcode;
		logic [2:0]  funct3;
		logic [6:0]  funct7;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [19:0] raw_imm;
		fmt_e        fmt;
	} fields_t;

	typedef enum logic [3:0] {
		alu_add    = 4'd0,
		alu_sub    = 4'd1,
		alu_sll    = 4'd2,
		alu_slt    = 4'd3,
		alu_sltu   = 4'd4,
		alu_xor    = 4'd5,
		alu_srl    = 4'd6,
		alu_sra    = 4'd7,
		alu_or     = 4'd8,
		alu_and    = 4'd9,
		alu_pass_b = 4'd10
	} alu_op_e;

	typedef struct packed {
		alu_op_e alu_op;
		logic    src_a_pc;  // operand a is the pc.
		logic    src_b_imm; // operand b is the immediate.
		logic    mem_read;
		logic    mem_write;
		logic    reg_write;
		logic    branch;
		logic    jump;
		logic    link;      // rd gets pc + 4.
		logic    system;
		logic    illegal;
	} ctrl_t;

	typedef struct packed {
		logic [31:0] rs1_data;
		logic [31:0] rs2_data;
		logic [31:0] imm;
		logic [4:0]  rd;
		logic [2:0]  funct3;
		ctrl_t       ctrl;
	} decoded_t;

	typedef struct packed {
		logic [4:0]  rd;
		logic [31:0] data;
	} wb_t;

endpackage
